// File: src/ddr_app_pkg.sv
`default_nettype none

package ddr_app_pkg;

   // app command codes, as seen on the controller's cmd field
   typedef enum logic [2:0] {
      cmd_write = 3'd0,
      cmd_read  = 3'd1
   } app_cmd_e;

   // one app beat, i.e. one sample
   localparam int data_width = 32;

   // app byte address
   localparam int addr_width = 30;

   // byte step between consecutive 64-bit words
   localparam int burst_stride = 8;

   // burst and readback counters
   localparam int count_width = 16;

   // one stored word, seen whole or as its two beats
   // hi is the first sample on the bus, lo the second
   typedef union packed {
      logic [2*data_width-1:0] raw;
      struct packed {
         logic [data_width-1:0] hi;
         logic [data_width-1:0] lo;
      } beats;
   } burst_word_u;

endpackage

`default_nettype wire

// File: src/ddr_app_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ddr_app_if;
   import ddr_app_pkg::*;

   // merged command bus, as the memory sees it
   logic [addr_width-1:0] addr;
   app_cmd_e              cmd;
   logic                  en;
   // write data, from the writer only
   logic [data_width-1:0] wdf_data;
   logic                  wdf_end;
   logic                  wdf_wren;
   // read return and flow control, from the memory
   logic [data_width-1:0] rd_data;
   logic                  rd_data_valid;
   logic                  rd_data_end;
   logic                  rdy;

   // per-side command requests
   logic [addr_width-1:0] wr_req_addr;
   app_cmd_e              wr_req_cmd;
   logic                  wr_req_en;
   logic [addr_width-1:0] rd_req_addr;
   app_cmd_e              rd_req_cmd;
   logic                  rd_req_en;
   // reader holds the command bus during a readback
   logic                  rd_owner;

   assign addr = rd_owner ? rd_req_addr : wr_req_addr;
   assign cmd  = rd_owner ? rd_req_cmd : wr_req_cmd;
   assign en   = rd_owner ? rd_req_en : wr_req_en;

   modport mem (
      input  addr, cmd, en, wdf_data, wdf_end, wdf_wren,
      output rd_data, rd_data_valid, rd_data_end, rdy
   );

   modport ctrl_wr (
      output wr_req_addr, wr_req_cmd, wr_req_en, wdf_data, wdf_end, wdf_wren,
      input  rdy
   );

   modport ctrl_rd (
      output rd_req_addr, rd_req_cmd, rd_req_en, rd_owner,
      input  rdy, rd_data, rd_data_valid, rd_data_end
   );

endinterface

`default_nettype wire

// File: src/ddr_read_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module ddr_read_fifo #(
   parameter int fifo_depth     = 32,
   parameter int fifo_prog_full = 16
) (
   input  wire                       clk,
   input  wire                       reset,
   input  wire ddr_app_pkg::burst_word_u din,
   input  wire                       wr_en,
   input  wire                       rd_en,
   output ddr_app_pkg::burst_word_u  dout,
   output logic                      full,
   output logic                      empty,
   output logic                      prog_full,
   output logic                      overflow
);
   import ddr_app_pkg::*;

   localparam int ptr_width = $clog2(fifo_depth);
   localparam int lvl_width = $clog2(fifo_depth + 1);

   burst_word_u           mem [fifo_depth];
   logic [ptr_width-1:0]  wr_ptr;
   logic [ptr_width-1:0]  rd_ptr;
   logic [lvl_width-1:0]  level;
   logic                  do_wr;
   logic                  do_rd;

   // writes while full are lost, reads while empty ignored
   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   assign full      = level == lvl_width'(fifo_depth);
   assign empty     = level == '0;
   // early warning, leaves room for requests in flight
   assign prog_full = level >= lvl_width'(fifo_prog_full);

   // show-ahead, head word always on dout
   assign dout = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         level    <= '0;
         overflow <= 1'b0;
      end else begin
         if (do_wr)
            wr_ptr <= (wr_ptr == ptr_width'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= (rd_ptr == ptr_width'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;
         endcase
         // sticky until reset
         if (wr_en && full)
            overflow <= 1'b1;
      end
   end

   // storage
   always_ff @(posedge clk) begin
      if (do_wr)
         mem[wr_ptr] <= din;
   end

endmodule

`default_nettype wire

// File: src/ddr_app_model.sv
`timescale 1ns/1ps
`default_nettype none

module ddr_app_model #(
   parameter int model_depth    = 1024,
   parameter int calib_cycles   = 64,
   parameter int fifo_depth     = 32,
   parameter int fifo_prog_full = 16
) (
   input  wire       clk,
   input  wire       reset,
   ddr_app_if.mem    app,
   output logic      calib_done
);
   import ddr_app_pkg::*;

   localparam int idx_width    = $clog2(model_depth);
   localparam int stride_shift = $clog2(burst_stride);
   localparam int calib_width  = $clog2(calib_cycles);

   burst_word_u              mem [model_depth];
   logic [idx_width-1:0]     cmd_idx;
   logic [calib_width-1:0]   calib_cnt;
   logic [15:0]              lfsr;
   // write assembly
   logic                     wr_pending;
   logic                     wr_first;
   logic                     wr_second;
   logic [data_width-1:0]    wr_hi;
   logic [idx_width-1:0]     wr_idx;
   burst_word_u              wr_word;
   // ready throttling
   logic [2:0]               stall_cnt;
   logic                     wr_parity;
   // read queue and output stage
   logic                     rd_req;
   logic                     fifo_wr;
   burst_word_u              fifo_in;
   burst_word_u              fifo_out;
   logic                     fifo_empty;
   logic                     fifo_prog;
   logic                     drain_ok;
   logic                     pop;
   logic                     out_phase;
   logic [data_width-1:0]    out_lo;

   // byte address to word index
   assign cmd_idx = app.addr[stride_shift +: idx_width];

   // no accepts before calibration, near-full FIFO or in a stall window
   assign app.rdy = calib_done && !fifo_prog && (stall_cnt == '0);

   // command beat, then end beat
   assign wr_first  = app.en && app.rdy && (app.cmd == cmd_write) && app.wdf_wren && !wr_pending;
   assign wr_second = wr_pending && app.wdf_wren && app.wdf_end && app.rdy;
   assign rd_req    = app.en && app.rdy && (app.cmd == cmd_read);

   always_comb begin
      wr_word.beats.hi = wr_hi;
      wr_word.beats.lo = app.wdf_data;
   end

   // drain gaps, about one cycle in four held back
   assign drain_ok = lfsr[7:6] != 2'b00;
   assign pop      = !fifo_empty && !out_phase && drain_ok;

   always_ff @(posedge clk) begin
      if (reset) begin
         calib_done        <= 1'b0;
         calib_cnt         <= '0;
         lfsr              <= 16'hace1;
         wr_pending        <= 1'b0;
         wr_parity         <= 1'b0;
         stall_cnt         <= '0;
         fifo_wr           <= 1'b0;
         out_phase         <= 1'b0;
         app.rd_data_valid <= 1'b0;
         app.rd_data_end   <= 1'b0;
      end else begin
         // x^16 + x^15 + x^13 + x^4 + 1
         lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3]};
         // start-up delay
         if (!calib_done) begin
            calib_cnt <= calib_cnt + 1'b1;
            if (calib_cnt == calib_width'(calib_cycles - 1))
               calib_done <= 1'b1;
         end
         if (wr_first)
            wr_pending <= 1'b1;
         else if (wr_second)
            wr_pending <= 1'b0;
         if (stall_cnt != '0)
            stall_cnt <= stall_cnt - 1'b1;
         // at most one stall window per two stored words, 1 to 7 cycles
         if (wr_second) begin
            wr_parity <= !wr_parity;
            if (wr_parity && lfsr[0] && (stall_cnt == '0))
               stall_cnt <= (lfsr[3:1] == 3'd0) ? 3'd7 : lfsr[3:1];
         end
         fifo_wr <= rd_req;
         // two beats per popped word, end on the second
         app.rd_data_valid <= pop || out_phase;
         app.rd_data_end   <= out_phase;
         out_phase         <= pop;
      end
   end

   // storage and beat payload
   always_ff @(posedge clk) begin
      if (wr_first) begin
         wr_hi  <= app.wdf_data;
         wr_idx <= cmd_idx;
      end
      if (wr_second)
         mem[wr_idx] <= wr_word;
      // word fetched as the read is accepted
      fifo_in <= mem[cmd_idx];
      if (pop) begin
         app.rd_data <= fifo_out.beats.hi;
         out_lo      <= fifo_out.beats.lo;
      end else if (out_phase) begin
         app.rd_data <= out_lo;
      end
   end

   // overflow kept as sticky status inside the FIFO
   ddr_read_fifo #(
      .fifo_depth     (fifo_depth),
      .fifo_prog_full (fifo_prog_full)
   ) i_ddr_read_fifo (
      .clk       (clk),
      .reset     (reset),
      .din       (fifo_in),
      .wr_en     (fifo_wr),
      .rd_en     (pop),
      .dout      (fifo_out),
      .full      (),
      .empty     (fifo_empty),
      .prog_full (fifo_prog),
      .overflow  ()
   );

endmodule

`default_nettype wire

// File: src/sample_ddr_writer.sv
`timescale 1ns/1ps
`default_nettype none

module sample_ddr_writer (
   input  wire                                  clk,
   input  wire                                  reset,
   input  wire [ddr_app_pkg::data_width-1:0]    sample_data,
   input  wire                                  sample_valid,
   input  wire                                  capture_arm,
   input  wire                                  bus_hold,
   ddr_app_if.ctrl_wr                           app,
   output logic [ddr_app_pkg::count_width-1:0]  bursts_written,
   output logic                                 capture_overflow
);
   import ddr_app_pkg::*;

   // first sample of the pair being built
   logic [data_width-1:0] half_data;
   logic                  half_valid;
   burst_word_u           pair_word;
   // four-entry burst buffer
   burst_word_u           buf_mem [4];
   logic [1:0]            buf_wr_ptr;
   logic [1:0]            buf_rd_ptr;
   logic [2:0]            buf_count;
   logic                  push;
   logic                  pop;
   // write sequencing
   logic                  start;
   logic                  wr_beat2;
   logic [addr_width-1:0] wr_addr;

   always_comb begin
      pair_word.beats.hi = half_data;
      pair_word.beats.lo = sample_data;
   end

   // end beat taken, buffer slot frees up
   assign pop   = wr_beat2 && app.rdy;
   // a full buffer still takes the burst if a slot frees this cycle
   assign push  = sample_valid && half_valid && ((buf_count != 3'd4) || pop);
   // command beat, reader has the bus while bus_hold
   assign start = !wr_beat2 && (buf_count != 3'd0) && !bus_hold;

   assign app.wr_req_en   = start;
   assign app.wr_req_addr = wr_addr;
   assign app.wr_req_cmd  = cmd_write;
   assign app.wdf_wren    = start || wr_beat2;
   assign app.wdf_end     = wr_beat2;
   assign app.wdf_data    = wr_beat2 ? buf_mem[buf_rd_ptr].beats.lo
                                     : buf_mem[buf_rd_ptr].beats.hi;

   always_ff @(posedge clk) begin
      if (reset) begin
         half_valid       <= 1'b0;
         buf_wr_ptr       <= '0;
         buf_rd_ptr       <= '0;
         buf_count        <= '0;
         wr_beat2         <= 1'b0;
         wr_addr          <= '0;
         bursts_written   <= '0;
         capture_overflow <= 1'b0;
      end else begin
         if (sample_valid)
            half_valid <= !half_valid;
         if (push)
            buf_wr_ptr <= buf_wr_ptr + 1'b1;
         // fifth burst lost, flag stays up until reset
         if (sample_valid && half_valid && !push)
            capture_overflow <= 1'b1;
         if (start && app.rdy)
            wr_beat2 <= 1'b1;
         if (pop) begin
            wr_beat2       <= 1'b0;
            buf_rd_ptr     <= buf_rd_ptr + 1'b1;
            wr_addr        <= wr_addr + addr_width'(burst_stride);
            bursts_written <= bursts_written + 1'b1;
         end
         buf_count <= buf_count + {2'b00, push} - {2'b00, pop};
         // new capture from word zero
         if (capture_arm) begin
            half_valid     <= 1'b0;
            wr_addr        <= '0;
            bursts_written <= '0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (sample_valid && !half_valid)
         half_data <= sample_data;
      if (push)
         buf_mem[buf_wr_ptr] <= pair_word;
   end

endmodule

`default_nettype wire

// File: src/sample_ddr_reader.sv
`timescale 1ns/1ps
`default_nettype none

module sample_ddr_reader (
   input  wire                                  clk,
   input  wire                                  reset,
   input  wire                                  read_start,
   input  wire [ddr_app_pkg::addr_width-1:0]    read_addr,
   input  wire [ddr_app_pkg::count_width-1:0]   read_count,
   ddr_app_if.ctrl_rd                           app,
   output logic                                 busy,
   output logic [ddr_app_pkg::data_width-1:0]   read_sample,
   output logic                                 read_sample_valid,
   output logic                                 read_done
);
   import ddr_app_pkg::*;

   logic [addr_width-1:0]  issue_addr;
   // reads still to issue
   logic [count_width-1:0] issue_left;
   // end beats still to come back
   logic [count_width-1:0] ends_left;
   logic                   req;
   logic                   issue_ok;
   logic                   end_beat;

   assign req      = busy && (issue_left != '0);
   assign issue_ok = req && app.rdy;
   assign end_beat = app.rd_data_valid && app.rd_data_end;

   assign app.rd_req_en   = req;
   assign app.rd_req_addr = issue_addr;
   assign app.rd_req_cmd  = cmd_read;
   assign app.rd_owner    = busy;

   always_ff @(posedge clk) begin
      if (reset) begin
         busy              <= 1'b0;
         issue_left        <= '0;
         ends_left         <= '0;
         read_sample_valid <= 1'b0;
         read_done         <= 1'b0;
      end else begin
         // every returned beat is one sample
         read_sample_valid <= app.rd_data_valid;
         read_done         <= 1'b0;
         if (!busy) begin
            if (read_start) begin
               busy       <= read_count != '0;
               issue_left <= read_count;
               ends_left  <= read_count;
               // empty range finishes at once
               read_done  <= read_count == '0;
            end
         end else begin
            if (issue_ok)
               issue_left <= issue_left - 1'b1;
            if (end_beat) begin
               ends_left <= ends_left - 1'b1;
               if (ends_left == count_width'(1)) begin
                  busy      <= 1'b0;
                  read_done <= 1'b1;
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!busy && read_start)
         issue_addr <= read_addr;
      else if (issue_ok)
         issue_addr <= issue_addr + addr_width'(burst_stride);
      read_sample <= app.rd_data;
   end

endmodule

`default_nettype wire

// File: src/capture_ddr_top.sv
`timescale 1ns/1ps
`default_nettype none

module capture_ddr_top #(
   parameter int model_depth    = 1024,
   parameter int calib_cycles   = 64,
   parameter int fifo_depth     = 32,
   parameter int fifo_prog_full = 16
) (
   input  wire                                  clk,
   input  wire                                  reset,
   // capture side
   input  wire [ddr_app_pkg::data_width-1:0]    sample_data,
   input  wire                                  sample_valid,
   input  wire                                  capture_arm,
   // readback request
   input  wire                                  read_start,
   input  wire [ddr_app_pkg::addr_width-1:0]    read_addr,
   input  wire [ddr_app_pkg::count_width-1:0]   read_count,
   output logic                                 calib_done,
   output logic [ddr_app_pkg::count_width-1:0]  bursts_written,
   output logic                                 capture_overflow,
   output logic [ddr_app_pkg::data_width-1:0]   read_sample,
   output logic                                 read_sample_valid,
   output logic                                 read_done
);

   // reader busy keeps the writer off the command bus
   logic      rd_busy;

   // one app bus shared by writer and reader
   ddr_app_if app_bus ();

   ddr_app_model #(
      .model_depth    (model_depth),
      .calib_cycles   (calib_cycles),
      .fifo_depth     (fifo_depth),
      .fifo_prog_full (fifo_prog_full)
   ) i_ddr_app_model (
      .clk        (clk),
      .reset      (reset),
      .app        (app_bus.mem),
      .calib_done (calib_done)
   );

   sample_ddr_writer i_sample_ddr_writer (
      .clk              (clk),
      .reset            (reset),
      .sample_data      (sample_data),
      .sample_valid     (sample_valid),
      .capture_arm      (capture_arm),
      .bus_hold         (rd_busy),
      .app              (app_bus.ctrl_wr),
      .bursts_written   (bursts_written),
      .capture_overflow (capture_overflow)
   );

   sample_ddr_reader i_sample_ddr_reader (
      .clk               (clk),
      .reset             (reset),
      .read_start        (read_start),
      .read_addr         (read_addr),
      .read_count        (read_count),
      .app               (app_bus.ctrl_rd),
      .busy              (rd_busy),
      .read_sample       (read_sample),
      .read_sample_valid (read_sample_valid),
      .read_done         (read_done)
   );

endmodule

`default_nettype wire

// File: verif/capture_ddr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module capture_ddr_tb;
   import ddr_app_pkg::*;

   localparam string data_path     = "verif/capture_ddr_testdata.txt";
   localparam int    calib_timeout = 500;
   localparam int    write_timeout = 400;
   localparam int    read_timeout  = 4000;
   // strobe spacing in clock cycles
   localparam int    sample_gap    = 8;

   logic                   clk = 1'b0;
   logic                   reset;
   logic [data_width-1:0]  sample_data;
   logic                   sample_valid;
   logic                   capture_arm;
   logic                   read_start;
   logic [addr_width-1:0]  read_addr;
   logic [count_width-1:0] read_count;
   logic                   calib_done;
   logic [count_width-1:0] bursts_written;
   logic                   capture_overflow;
   logic [data_width-1:0]  read_sample;
   logic                   read_sample_valid;
   logic                   read_done;

   int checks;
   int errors;
   int timeouts;
   // bursts since the last arm
   int expected_bursts;

   // 4 ns period
   always #2 clk = ~clk;

   capture_ddr_top i_capture_ddr_top (
      .clk               (clk),
      .reset             (reset),
      .sample_data       (sample_data),
      .sample_valid      (sample_valid),
      .capture_arm       (capture_arm),
      .read_start        (read_start),
      .read_addr         (read_addr),
      .read_count        (read_count),
      .calib_done        (calib_done),
      .bursts_written    (bursts_written),
      .capture_overflow  (capture_overflow),
      .read_sample       (read_sample),
      .read_sample_valid (read_sample_valid),
      .read_done         (read_done)
   );

   task automatic check_value(input string test, input string what,
                              input logic [63:0] expected, input logic [63:0] actual);
      checks++;
      assert (actual === expected) else begin
         errors++;
         $display("[ERROR] %0s %0s: expected %0h, actual %0h", test, what, expected, actual);
      end
   endtask

   task automatic wait_calib();
      int cycles;
      cycles = 0;
      while (!calib_done && cycles < calib_timeout) begin
         @(negedge clk);
         cycles++;
      end
      assert (calib_done) else begin
         timeouts++;
         $display("timeout: calib_done still low after %0d cycles", calib_timeout);
      end
   endtask

   // one-cycle arm pulse, address back to word zero
   task automatic arm_capture();
      @(negedge clk);
      capture_arm = 1'b1;
      @(negedge clk);
      capture_arm = 1'b0;
   endtask

   task automatic write_samples(input logic [data_width-1:0] samples[$]);
      foreach (samples[i]) begin
         @(negedge clk);
         sample_data  = samples[i];
         sample_valid = 1'b1;
         @(negedge clk);
         sample_valid = 1'b0;
         repeat (sample_gap - 2) @(negedge clk);
      end
   endtask

   task automatic wait_bursts(input string test, input int target);
      int cycles;
      cycles = 0;
      while (int'(bursts_written) != target && cycles < write_timeout) begin
         @(negedge clk);
         cycles++;
      end
      assert (int'(bursts_written) == target) else begin
         timeouts++;
         $display("timeout: %0s wrote %0d bursts, %0d were due", test, bursts_written, target);
      end
   endtask

   task automatic readback(input string test, input logic [addr_width-1:0] addr,
                           input int count, input logic [data_width-1:0] expect_q[$]);
      logic [data_width-1:0] got[$];
      int                    cycles;
      bit                    done;
      got    = {};
      cycles = 0;
      done   = 1'b0;
      @(negedge clk);
      read_addr  = addr;
      read_count = count_width'(count);
      read_start = 1'b1;
      @(negedge clk);
      read_start = 1'b0;
      // last sample and read_done land in the same cycle
      while (!done && cycles < read_timeout) begin
         if (read_sample_valid)
            got.push_back(read_sample);
         if (read_done)
            done = 1'b1;
         else begin
            @(negedge clk);
            cycles++;
         end
      end
      assert (done) else begin
         timeouts++;
         $display("timeout: %0s readback never signalled read_done", test);
      end
      check_value(test, "beat count", expect_q.size(), got.size());
      for (int i = 0; i < expect_q.size() && i < got.size(); i++)
         check_value(test, $sformatf("sample %0d", i), expect_q[i], got[i]);
      // nothing trails the done pulse
      @(negedge clk);
      check_value(test, "valid after done", 1'b0, read_sample_valid);
      check_value(test, "done pulse width", 1'b0, read_done);
   endtask

   initial begin
      int                    fd;
      int                    rc;
      int                    arm;
      int                    nsamp;
      int                    rcount;
      int                    tests;
      logic [8*32-1:0]       tok;
      logic [8*256-1:0]      rest;
      logic [data_width-1:0] value;
      logic [addr_width-1:0] raddr;
      logic [data_width-1:0] samples[$];
      logic [data_width-1:0] expect_q[$];
      string                 test;

      checks          = 0;
      errors          = 0;
      timeouts        = 0;
      tests           = 0;
      expected_bursts = 0;
      reset           = 1'b1;
      sample_data     = '0;
      sample_valid    = 1'b0;
      capture_arm     = 1'b0;
      read_start      = 1'b0;
      read_addr       = '0;
      read_count      = '0;

      repeat (16) @(negedge clk);
      reset = 1'b0;
      check_value("reset", "calib_done", 1'b0, calib_done);
      check_value("reset", "capture_overflow", 1'b0, capture_overflow);
      check_value("reset", "read_done", 1'b0, read_done);
      check_value("reset", "read_sample_valid", 1'b0, read_sample_valid);
      wait_calib();

      fd = $fopen(data_path, "r");
      if (fd == 0) begin
         errors++;
         $display("could not open the test data file %0s", data_path);
      end else begin
         rc = $fscanf(fd, "%s", tok);
         while (rc == 1) begin
            if (tok == "#") begin
               // rest of a comment line
               rc = $fgets(rest, fd);
            end else begin
               test = $sformatf("%0s", tok);
               tests++;
               rc = $fscanf(fd, "%d %d", arm, nsamp);
               samples = {};
               for (int i = 0; i < nsamp; i++) begin
                  rc = $fscanf(fd, "%h", value);
                  samples.push_back(value);
               end
               if (arm != 0) begin
                  arm_capture();
                  expected_bursts = 0;
               end
               write_samples(samples);
               // two samples per burst
               expected_bursts += nsamp / 2;
               if (nsamp > 0)
                  wait_bursts(test, expected_bursts);
               check_value(test, "capture_overflow", 1'b0, capture_overflow);
               rc = $fscanf(fd, "%h %d", raddr, rcount);
               expect_q = {};
               for (int i = 0; i < 2 * rcount; i++) begin
                  rc = $fscanf(fd, "%h", value);
                  expect_q.push_back(value);
               end
               readback(test, raddr, rcount, expect_q);
               // no stray writes once the capture has settled
               check_value(test, "bursts_written", expected_bursts, bursts_written);
            end
            rc = $fscanf(fd, "%s", tok);
         end
         $fclose(fd);
         if (tests == 0) begin
            errors++;
            $display("the test data file held no test records");
         end
      end

      check_value("end", "capture_overflow", 1'b0, capture_overflow);
      $display("closing: %0d tests, %0d checks, %0d errors, %0d timeouts",
               tests, checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/capture_ddr_testdata.txt
# record: name arm sample_count, then the samples in hex
# then read_addr (hex byte address) read_count (bursts), then the expected samples in hex
# first capture, eight samples into words 0 to 3
full_range 1 8
11110000 11110001 11110002 11110003 11110004 11110005 11110006 11110007
0 4
11110000 11110001 11110002 11110003 11110004 11110005 11110006 11110007
# word 2 onward, byte address 0x10
from_word2 0 0
10 2
11110004 11110005 11110006 11110007
# last word alone
last_word 0 0
18 1
11110006 11110007
# re-arm, three new words overwrite words 0 to 2, word 3 keeps its old pair
rearm 1 6
a5a50000 a5a50001 a5a50002 a5a50003 a5a50004 a5a50005
0 4
a5a50000 a5a50001 a5a50002 a5a50003 a5a50004 a5a50005 11110006 11110007
# six words, read back words 1 to 5
long_run 1 12
c0de0000 c0de0001 c0de0002 c0de0003 c0de0004 c0de0005 c0de0006 c0de0007
c0de0008 c0de0009 c0de000a c0de000b
8 5
c0de0002 c0de0003 c0de0004 c0de0005 c0de0006 c0de0007 c0de0008 c0de0009
c0de000a c0de000b

// File: verilog.f
src/ddr_app_pkg.sv
src/ddr_app_if.sv
src/ddr_read_fifo.sv
src/ddr_app_model.sv
src/sample_ddr_writer.sv
src/sample_ddr_reader.sv
src/capture_ddr_top.sv
verif/capture_ddr_tb.sv

// File: Makefile
# Verilator build and run for the DDR capture testbench

VERILATOR ?= verilator
TOP       ?= capture_ddr_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the exact pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
